//--- hdl/mesh_route_unit.sv
`timescale 1ns/1ps

module mesh_route_unit import route_pkg::*; #(
    parameter  int NX    = 4,
    parameter  int NY    = 4,
    parameter  int IN_NI = 0,
    localparam int XW    = (NX > 1) ? $clog2(NX) : 1,
    localparam int YW    = (NY > 1) ? $clog2(NY) : 1
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  logic [1:0]       adr,
    input  logic [WB_DW-1:0] dat_w,
    output logic [WB_DW-1:0] dat_r,
    output logic             ack
);

    // bus side to candidate stage
    logic [XW-1:0] cur_x;
    logic [YW-1:0] cur_y;
    logic [XW-1:0] dst_x;
    logic [YW-1:0] dst_y;
    route_alg_e    alg;
    logic          launch;

    // candidate stage to encoder
    logic                 cand_valid;
    logic [NUM_PORTS-1:0] cand_mask;
    logic                 x_plus;
    logic                 y_min;

    // stored result back to the bus
    logic [NUM_PORTS-1:0] res_mask;
    logic [CODE_W-1:0]    res_code;
    logic [COUNT_W-1:0]   res_count;

    route_wb_regs #(
        .NX (NX),
        .NY (NY)
    ) route_wb_regs_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .dat_r     (dat_r),
        .ack       (ack),
        .cur_x     (cur_x),
        .cur_y     (cur_y),
        .dst_x     (dst_x),
        .dst_y     (dst_y),
        .alg       (alg),
        .launch    (launch),
        .res_mask  (res_mask),
        .res_code  (res_code),
        .res_count (res_count)
    );

    route_candidates #(
        .NX    (NX),
        .NY    (NY),
        .IN_NI (IN_NI)
    ) route_candidates_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .launch     (launch),
        .cur_x      (cur_x),
        .cur_y      (cur_y),
        .dst_x      (dst_x),
        .dst_y      (dst_y),
        .alg        (alg),
        .cand_valid (cand_valid),
        .cand_mask  (cand_mask),
        .x_plus     (x_plus),
        .y_min      (y_min)
    );

    route_port_encode route_port_encode_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .cand_valid (cand_valid),
        .cand_mask  (cand_mask),
        .x_plus     (x_plus),
        .y_min      (y_min),
        .res_mask   (res_mask),
        .res_code   (res_code),
        .res_count  (res_count)
    );

endmodule

//--- hdl/route_candidates.sv
`timescale 1ns/1ps

module route_candidates import route_pkg::*; #(
    parameter  int NX    = 4,
    parameter  int NY    = 4,
    parameter  int IN_NI = 0,   // 1: routing sits in the NI, 0: inside the router
    localparam int XW    = (NX > 1) ? $clog2(NX) : 1,
    localparam int YW    = (NY > 1) ? $clog2(NY) : 1
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 launch,
    input  logic [XW-1:0]        cur_x,
    input  logic [YW-1:0]        cur_y,
    input  logic [XW-1:0]        dst_x,
    input  logic [YW-1:0]        dst_y,
    input  route_alg_e           alg,
    output logic                 cand_valid,
    output logic [NUM_PORTS-1:0] cand_mask,
    output logic                 x_plus,
    output logic                 y_min
);

    // coordinate compare, y grows southward
    logic same_x, same_y;
    logic x_pl, x_mn;
    logic y_mn;
    port_e y_dir;         // the y port when y differs
    logic [XW:0] x_dist;  // dst - cur, only meaningful eastbound

    logic [NUM_PORTS-1:0] xy_mask;
    logic [NUM_PORTS-1:0] wf_mask;
    logic [NUM_PORTS-1:0] oe_mask;
    logic [NUM_PORTS-1:0] mask_next;

    assign same_x = (dst_x == cur_x);
    assign same_y = (dst_y == cur_y);
    assign x_pl   = (dst_x > cur_x);
    assign x_mn   = (dst_x < cur_x);
    assign y_mn   = (dst_y < cur_y);
    assign y_dir  = y_mn ? NORTH : SOUTH;
    assign x_dist = {1'b0, dst_x} - {1'b0, cur_x};

    // dimension order, x first
    always_comb begin
        xy_mask = '0;
        if (x_pl)
            xy_mask[EAST] = 1'b1;
        else if (x_mn)
            xy_mask[WEST] = 1'b1;
        else if (!same_y)
            xy_mask[y_dir] = 1'b1;
        else
            xy_mask[LOCAL] = 1'b1;   // arrived
    end

    // west first: any west hop is taken before turning
    always_comb begin
        wf_mask = '0;
        if (same_x && same_y) begin
            wf_mask[LOCAL] = 1'b1;
        end else if (x_mn) begin
            wf_mask[WEST] = 1'b1;   // no north/south while west is pending
        end else if (x_pl) begin
            wf_mask[EAST] = 1'b1;
            if (!same_y)
                wf_mask[y_dir] = 1'b1;
        end else begin
            wf_mask[y_dir] = 1'b1;   // same column
        end
    end

    // odd-even turn model
    always_comb begin
        oe_mask = '0;
        if (same_x && same_y) begin
            oe_mask[LOCAL] = 1'b1;
        end else if (same_x) begin
            oe_mask[y_dir] = 1'b1;
        end else if (same_y) begin
            oe_mask[x_pl ? EAST : WEST] = 1'b1;
        end else if (x_pl) begin
            // eastbound, y turn only from odd column unless in NI
            if (cur_x[0] || (IN_NI == 1))
                oe_mask[y_dir] = 1'b1;
            // keep east open if dest column odd or 2+ columns away
            if (dst_x[0] || (x_dist != (XW+1)'(1)))
                oe_mask[EAST] = 1'b1;
        end else begin
            oe_mask[WEST] = 1'b1;   // westbound
            if (!cur_x[0])
                oe_mask[y_dir] = 1'b1;   // even column
        end
    end

    always_comb begin
        case (alg)
            ALG_WEST_FIRST: mask_next = wf_mask;
            ALG_ODD_EVEN:   mask_next = oe_mask;
            default:        mask_next = xy_mask;   // xy and opcode 3
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            cand_valid <= 1'b0;
        else
            cand_valid <= launch;
    end

    // payload, sampled only behind cand_valid
    always_ff @(posedge clk) begin
        if (launch) begin
            cand_mask <= mask_next;
            x_plus    <= x_pl;
            y_min     <= y_mn;
        end
    end

endmodule

//--- hdl/route_pkg.sv
package route_pkg;

    // router ports, the value doubles as bit position in a port mask
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        EAST  = 3'd1,
        NORTH = 3'd2,
        WEST  = 3'd3,
        SOUTH = 3'd4
    } port_e;

    // routing algorithm opcode; 3 is left unnamed and routes as xy
    typedef enum logic [1:0] {
        ALG_XY         = 2'd0,
        ALG_WEST_FIRST = 2'd1,   // partially adaptive
        ALG_ODD_EVEN   = 2'd2    // partially adaptive
    } route_alg_e;

    // wishbone word addresses, 3 reads as zero
    typedef enum logic [1:0] {
        REG_LOC    = 2'd0,
        REG_REQ    = 2'd1,
        REG_RESULT = 2'd2
    } reg_addr_e;

    localparam int NUM_PORTS = 5;   // always 5 in a 2D mesh
    localparam int CODE_W    = 4;   // {x_plus, y_min, ew, ns}
    localparam int WB_DW     = 32;
    localparam int ALG_W     = 2;
    localparam int COUNT_W   = 8;   // completed route counter

    // LOC and REQ field positions
    localparam int X_POS   = 0;
    localparam int Y_POS   = 8;
    localparam int ALG_POS = 16;

    // RESULT field positions
    localparam int MASK_POS  = 0;
    localparam int CODE_POS  = 8;
    localparam int COUNT_POS = 24;

endpackage

//--- hdl/route_port_encode.sv
`timescale 1ns/1ps

module route_port_encode import route_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 cand_valid,
    input  logic [NUM_PORTS-1:0] cand_mask,
    input  logic                 x_plus,
    input  logic                 y_min,
    output logic [NUM_PORTS-1:0] res_mask,
    output logic [CODE_W-1:0]    res_code,
    output logic [COUNT_W-1:0]   res_count
);

    logic ew_ok;   // east or west allowed
    logic ns_ok;   // north or south allowed
    logic [CODE_W-1:0] code_next;

    assign ew_ok = cand_mask[EAST] | cand_mask[WEST];
    assign ns_ok = cand_mask[NORTH] | cand_mask[SOUTH];

    // packed port code, msb first
    assign code_next = {x_plus, y_min, ew_ok, ns_ok};

    // result register, holds until the next route completes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_mask  <= '0;
            res_code  <= '0;
            res_count <= '0;
        end else if (cand_valid) begin
            res_mask  <= cand_mask;
            res_code  <= code_next;
            res_count <= res_count + 1'b1;   // wraps at 255
        end
    end

endmodule

//--- hdl/route_wb_regs.sv
`timescale 1ns/1ps

module route_wb_regs import route_pkg::*; #(
    parameter  int NX = 4,
    parameter  int NY = 4,
    localparam int XW = (NX > 1) ? $clog2(NX) : 1,
    localparam int YW = (NY > 1) ? $clog2(NY) : 1
) (
    input  logic               clk,
    input  logic               arst_n,
    // wishbone classic slave side
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  logic [1:0]         adr,
    input  logic [WB_DW-1:0]   dat_w,
    output logic [WB_DW-1:0]   dat_r,
    output logic               ack,
    // request towards the candidate stage
    output logic [XW-1:0]      cur_x,
    output logic [YW-1:0]      cur_y,
    output logic [XW-1:0]      dst_x,
    output logic [YW-1:0]      dst_y,
    output route_alg_e         alg,
    output logic               launch,
    // stored result for readback
    input  logic [NUM_PORTS-1:0] res_mask,
    input  logic [CODE_W-1:0]    res_code,
    input  logic [COUNT_W-1:0]   res_count
);

    reg_addr_e addr;
    logic      acc_new;   // first cycle of an access
    logic      wr_en;

    assign addr    = reg_addr_e'(adr);
    assign acc_new = cyc & stb & ~ack;   // ack still low, so this is a fresh cycle
    assign wr_en   = acc_new & we;

    // single cycle ack, launch lines up with the REQ write ack
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack    <= 1'b0;
            launch <= 1'b0;
        end else begin
            ack    <= acc_new;   // drops again on the next edge
            launch <= wr_en && (addr == REG_REQ);
        end
    end

    // location and request registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cur_x <= '0;
            cur_y <= '0;
            dst_x <= '0;
            dst_y <= '0;
            alg   <= ALG_XY;
        end else if (wr_en) begin
            case (addr)
                REG_LOC: begin
                    cur_x <= dat_w[X_POS +: XW];   // own router position
                    cur_y <= dat_w[Y_POS +: YW];
                end
                REG_REQ: begin
                    dst_x <= dat_w[X_POS +: XW];
                    dst_y <= dat_w[Y_POS +: YW];
                    alg   <= route_alg_e'(dat_w[ALG_POS +: ALG_W]);   // 3 kept as written
                end
                default: ;   // RESULT is read only, 3 ignored
            endcase
        end
    end

    // readback mux, held while ack is high
    always_comb begin
        dat_r = '0;
        case (addr)
            REG_LOC: begin
                dat_r[X_POS +: XW] = cur_x;
                dat_r[Y_POS +: YW] = cur_y;
            end
            REG_REQ: begin
                dat_r[X_POS +: XW]     = dst_x;
                dat_r[Y_POS +: YW]     = dst_y;
                dat_r[ALG_POS +: ALG_W] = alg;
            end
            REG_RESULT: begin
                dat_r[MASK_POS +: NUM_PORTS] = res_mask;
                dat_r[CODE_POS +: CODE_W]    = res_code;
                dat_r[COUNT_POS +: COUNT_W]  = res_count;
            end
            default: dat_r = '0;   // unmapped word
        endcase
    end

endmodule

//--- sim/route_tb_table.svh
// row fields in order are name opcode cur_x cur_y dst_x dst_y mask code
// mask bits L=0 E=1 N=2 W=3 S=4
// code packs {x_plus, y_min, ew, ns}
// y grows south
localparam int N_ROWS = 26;

task automatic fill_table();
    // dimension order
    add_row("xy_east",        0, 1, 1, 3, 1, 5'h02, 4'hA);
    add_row("xy_west",        0, 2, 1, 0, 3, 5'h08, 4'h2);
    add_row("xy_north",       0, 2, 2, 2, 0, 5'h04, 4'h5);
    add_row("xy_south",       0, 0, 1, 0, 3, 5'h10, 4'h1);
    add_row("xy_local",       0, 3, 3, 3, 3, 5'h01, 4'h0);
    add_row("xy_east_diag",   0, 0, 3, 2, 0, 5'h02, 4'hE);
    // west first over every quadrant and both axes
    add_row("wf_local",       1, 1, 2, 1, 2, 5'h01, 4'h0);
    add_row("wf_ne",          1, 1, 2, 3, 0, 5'h06, 4'hF);
    add_row("wf_se",          1, 0, 0, 2, 3, 5'h12, 4'hB);
    add_row("wf_nw",          1, 3, 3, 1, 1, 5'h08, 4'h6);   // no north while west pending
    add_row("wf_sw",          1, 2, 0, 0, 2, 5'h08, 4'h2);
    add_row("wf_east",        1, 0, 2, 3, 2, 5'h02, 4'hA);
    add_row("wf_west",        1, 3, 1, 0, 1, 5'h08, 4'h2);
    add_row("wf_north",       1, 2, 3, 2, 1, 5'h04, 4'h5);
    add_row("wf_south",       1, 1, 0, 1, 2, 5'h10, 4'h1);
    // odd-even with turns placed in the router
    add_row("oe_local",       2, 2, 2, 2, 2, 5'h01, 4'h0);
    add_row("oe_same_col",    2, 1, 3, 1, 0, 5'h04, 4'h5);
    add_row("oe_row_east",    2, 0, 1, 2, 1, 5'h02, 4'hA);
    add_row("oe_row_west",    2, 3, 0, 1, 0, 5'h08, 4'h2);
    add_row("oe_east_odd_cur", 2, 1, 0, 3, 2, 5'h12, 4'hB);
    add_row("oe_east_even_d2", 2, 0, 2, 2, 0, 5'h02, 4'hE);
    add_row("oe_east_even_d1", 2, 1, 1, 2, 3, 5'h10, 4'h9);   // east closed for even dest column
    add_row("oe_east_odd_d1", 2, 2, 3, 3, 1, 5'h02, 4'hE);
    add_row("oe_west_even",   2, 2, 0, 0, 3, 5'h18, 4'h3);
    add_row("oe_west_odd",    2, 3, 2, 1, 0, 5'h08, 4'h6);
    add_row("alg3_as_xy",     3, 1, 0, 3, 2, 5'h02, 4'hA);   // west first and odd-even give 5'h12
endtask

//--- sim/route_tb.sv
`timescale 1ns/1ps

module route_tb import route_pkg::*;;

    localparam int N_RAND = 40;   // random xy requests

    logic        clk;
    logic        arst_n;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;

    `include "route_tb_table.svh"

    // directed table rows
    string       row_name [N_ROWS];
    int          row_alg  [N_ROWS];
    int          row_cx   [N_ROWS];
    int          row_cy   [N_ROWS];
    int          row_dx   [N_ROWS];
    int          row_dy   [N_ROWS];
    logic [4:0]  row_mask [N_ROWS];
    logic [3:0]  row_code [N_ROWS];

    int          n_rows = 0;
    int          n_tests = 0;
    int          n_bad = 0;    // failed tests
    int          n_err = 0;    // failed checks
    int          err_at_start = 0;
    int          cx;
    int          cy;
    int          dx;
    int          dy;
    logic [4:0]  rmask;
    logic [7:0]  exp_count = '0;   // requests sent so far
    logic [31:0] rd;

    mesh_route_unit mesh_route_unit_i (.*);

    always #2 clk = ~clk;   // 4 ns period

    task automatic add_row(string name, int alg, int cx0, int cy0, int dx0, int dy0,
                           int mask, int code);
        row_name[n_rows] = name;
        row_alg[n_rows]  = alg;
        row_cx[n_rows]   = cx0;
        row_cy[n_rows]   = cy0;
        row_dx[n_rows]   = dx0;
        row_dy[n_rows]   = dy0;
        row_mask[n_rows] = mask[4:0];
        row_code[n_rows] = code[3:0];
        n_rows++;
    endtask

    // one wishbone classic access plus three idle cycles
    task automatic bus_cycle(input logic wr, input logic [1:0] a, input logic [31:0] d,
                             output logic [31:0] q);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= wr;
        adr   <= a;
        dat_w <= d;
        @(negedge clk);
        while (!ack)
            @(negedge clk);
        q = dat_r;   // valid while ack high
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic check_field(string name, string field, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %s %s expected %0h actual %0h", name, field, exp, act);
            n_err++;
        end
    endtask

    task automatic finish_test(string name);
        n_tests++;
        if (n_err != err_at_start) begin
            n_bad++;
            $display("test %s: FAIL", name);
        end else begin
            $display("test %s: ok", name);
        end
        err_at_start = n_err;
    endtask

    // LOC write then REQ write then RESULT read
    task automatic run_route(string name, int alg, int cx0, int cy0, int dx0, int dy0,
                             logic [4:0] mask, logic [3:0] code);
        logic [31:0] q;
        bus_cycle(1'b1, REG_LOC, cy0 * 256 + cx0, q);
        bus_cycle(1'b1, REG_REQ, alg * 65536 + dy0 * 256 + dx0, q);
        exp_count++;
        bus_cycle(1'b0, REG_RESULT, 32'd0, q);
        check_field(name, "mask", mask, q[4:0]);
        check_field(name, "code", code, q[11:8]);
        check_field(name, "count", exp_count, q[31:24]);
        finish_test(name);
    endtask

    // x before y and local on arrival
    function automatic logic [4:0] xy_mask(int cx0, int cy0, int dx0, int dy0);
        if (dx0 > cx0)
            return 5'b00010;
        if (dx0 < cx0)
            return 5'b01000;
        if (dy0 < cy0)
            return 5'b00100;
        if (dy0 > cy0)
            return 5'b10000;
        return 5'b00001;
    endfunction

    function automatic logic [3:0] pack_code(int cx0, int cy0, int dx0, int dy0,
                                             logic [4:0] mask);
        return {dx0 > cx0, dy0 < cy0, mask[1] | mask[3], mask[2] | mask[4]};
    endfunction

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = 2'd0;
        dat_w  = 32'd0;
        void'($urandom(89));
        fill_table();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        bus_cycle(1'b0, REG_LOC, 32'd0, rd);
        check_field("reset_values", "loc", 32'd0, rd);
        bus_cycle(1'b0, REG_RESULT, 32'd0, rd);
        check_field("reset_values", "result", 32'd0, rd);
        finish_test("reset_values");

        bus_cycle(1'b1, REG_LOC, 32'h0000_0302, rd);
        bus_cycle(1'b0, REG_LOC, 32'd0, rd);
        check_field("loc_readback", "loc", 32'h0000_0302, rd);
        finish_test("loc_readback");

        for (int i = 0; i < n_rows; i++)
            run_route(row_name[i], row_alg[i], row_cx[i], row_cy[i], row_dx[i], row_dy[i],
                      row_mask[i], row_code[i]);

        // last table request reads back unchanged
        bus_cycle(1'b0, REG_REQ, 32'd0, rd);
        check_field("req_readback", "req",
                    row_alg[n_rows-1] * 65536 + row_dy[n_rows-1] * 256 + row_dx[n_rows-1], rd);
        finish_test("req_readback");

        // LOC write and two RESULT reads leave the count alone
        bus_cycle(1'b1, REG_LOC, 32'h0000_0101, rd);
        bus_cycle(1'b0, REG_RESULT, 32'd0, rd);
        bus_cycle(1'b0, REG_RESULT, 32'd0, rd);
        check_field("count_hold", "count", exp_count, rd[31:24]);
        finish_test("count_hold");

        for (int i = 0; i < N_RAND; i++) begin
            cx = $urandom % 4;
            cy = $urandom % 4;
            dx = $urandom % 4;
            dy = $urandom % 4;
            rmask = xy_mask(cx, cy, dx, dy);
            run_route($sformatf("rand_xy_%0d", i), 0, cx, cy, dx, dy, rmask,
                      pack_code(cx, cy, dx, dy, rmask));
        end

        $display("tests %0d, failed %0d, check errors %0d", n_tests, n_bad, n_err);
        if (n_bad == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // about 40 cycles per route request
    initial begin
        #((N_ROWS + N_RAND) * 40 * 4);
        $display("watchdog expired, the DUT stopped answering before all tests ran");
        $display("Regression failed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+sim
hdl/route_pkg.sv
hdl/route_wb_regs.sv
hdl/route_candidates.sv
hdl/route_port_encode.sv
hdl/mesh_route_unit.sv
sim/route_tb.sv
